//--- compile.f
hw/uart_str_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/str_framer.sv
hw/str_deframer.sv
hw/uart_str_top.sv
verif/tb_uart_str.sv

//--- hw/str_deframer.sv
//==========================================================================
// string deframer
// hunts for "&&", collects content until the closing "&&" and hands
// the string to the host, flagging overlong content and framing errors
//==========================================================================
module str_deframer (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic [uart_str_pkg::DATA_BITS-1:0] byte_data,
	input  logic                               byte_vld,
	input  logic                               stop_err,
	output uart_str_pkg::str_msg_t             rx_msg,
	output logic                               rx_busy,
	output logic                               rx_done,
	output logic                               rx_error
);
	import uart_str_pkg::*;

	typedef enum logic [1:0] {
		DF_HUNT,
		DF_OPEN,
		DF_CONTENT,
		DF_CLOSE
	} df_state_t;

	df_state_t        state;
	logic [LEN_W-1:0] byte_cnt;
	logic [STR_W-1:0] work_text;
	logic [3:0]       wr_idx;
	logic [3:0]       wr_idx_next;
	logic             is_delim;
	logic             content_full;
	logic             pair_full;

	assign is_delim     = (byte_data == DELIM_CHAR);
	assign wr_idx       = byte_cnt[3:0];
	assign wr_idx_next  = wr_idx + 4'd1;
	assign content_full = (byte_cnt >= LEN_W'(MAX_CHARS));
	// room for a held ampersand plus the byte after it
	assign pair_full    = (byte_cnt >= LEN_W'(MAX_CHARS - 1));
	assign rx_busy      = (state == DF_CONTENT) || (state == DF_CLOSE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= DF_HUNT;
			byte_cnt <= '0;
			rx_msg   <= '0;
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (stop_err) begin
				// broken byte, only an error once inside a frame
				rx_error <= rx_busy;
				state    <= DF_HUNT;
			end else if (byte_vld) begin
				case (state)
					DF_HUNT: if (is_delim)
						state <= DF_OPEN;
					DF_OPEN: begin
						byte_cnt <= '0;
						state    <= is_delim ? DF_CONTENT : DF_HUNT;
					end
					DF_CONTENT: if (is_delim) begin
						state <= DF_CLOSE;
					end else if (content_full) begin
						rx_error <= 1'b1;
						state    <= DF_HUNT;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
					DF_CLOSE: if (is_delim) begin
						rx_done       <= 1'b1;
						rx_msg.text   <= work_text;
						rx_msg.length <= byte_cnt;
						state         <= DF_HUNT;
					end else if (pair_full) begin
						rx_error <= 1'b1;
						state    <= DF_HUNT;
					end else begin
						// lone ampersand was data after all
						byte_cnt <= byte_cnt + LEN_W'(2);
						state    <= DF_CONTENT;
					end
					default: state <= DF_HUNT;
				endcase
			end
		end
	end

	// content buffer, cleared at the start of each frame
	always_ff @(posedge sys_clk) begin
		if (byte_vld) begin
			if (state == DF_OPEN && is_delim) begin
				work_text <= '0;
			end else if (state == DF_CONTENT && !is_delim && !content_full) begin
				work_text[DATA_BITS*wr_idx +: DATA_BITS] <= byte_data;
			end else if (state == DF_CLOSE && !is_delim && !pair_full) begin
				work_text[DATA_BITS*wr_idx +: DATA_BITS]      <= DELIM_CHAR;
				work_text[DATA_BITS*wr_idx_next +: DATA_BITS] <= byte_data;
			end
		end
	end

	a_cnt_in_range: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_cnt <= LEN_W'(MAX_CHARS)
	) else $error("str_deframer: byte count past MAX_CHARS");

endmodule

//--- hw/str_framer.sv
//==========================================================================
// string framer
// captures one host message and feeds "&&", the content bytes and "&&"
// one at a time into the byte transmitter
//==========================================================================
module str_framer (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  uart_str_pkg::str_msg_t             tx_msg,
	input  logic                               tx_req,
	input  logic                               byte_done,
	output logic                               tx_busy,
	output logic                               tx_done,
	output logic [uart_str_pkg::DATA_BITS-1:0] byte_data,
	output logic                               byte_req
);
	import uart_str_pkg::*;

	typedef enum logic [6:0] {
		ST_IDLE    = 7'b000_0001,
		ST_OPEN1   = 7'b000_0010,
		ST_OPEN2   = 7'b000_0100,
		ST_CONTENT = 7'b000_1000,
		ST_CLOSE1  = 7'b001_0000,
		ST_CLOSE2  = 7'b010_0000,
		ST_FINISH  = 7'b100_0000
	} fr_state_t;

	fr_state_t            state;
	str_msg_t             msg_q;
	logic [LEN_W-1:0]     byte_cnt;
	logic [3:0]           char_idx;
	logic [DATA_BITS-1:0] cur_char;
	logic                 accept;

	assign tx_busy  = (state != ST_IDLE) && (state != ST_FINISH);
	assign tx_done  = (state == ST_FINISH);
	assign accept   = tx_req && !tx_busy;
	assign char_idx = byte_cnt[3:0];
	assign cur_char = msg_q.text[DATA_BITS*char_idx +: DATA_BITS];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= ST_IDLE;
			byte_cnt  <= '0;
			byte_data <= '0;
			byte_req  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				ST_IDLE, ST_FINISH: begin
					state <= ST_IDLE;
					if (accept) begin
						state     <= ST_OPEN1;
						byte_cnt  <= '0;
						byte_data <= DELIM_CHAR;
						byte_req  <= 1'b1;
					end
				end
				ST_OPEN1: if (byte_done) begin
					state     <= ST_OPEN2;
					byte_data <= DELIM_CHAR;
					byte_req  <= 1'b1;
				end
				ST_OPEN2: if (byte_done) begin
					byte_req <= 1'b1;
					if (msg_q.length == '0) begin
						// empty string, straight to the closing pair
						state     <= ST_CLOSE1;
						byte_data <= DELIM_CHAR;
					end else begin
						state     <= ST_CONTENT;
						byte_data <= cur_char;
						byte_cnt  <= byte_cnt + 1'b1;
					end
				end
				ST_CONTENT: if (byte_done) begin
					byte_req <= 1'b1;
					if (byte_cnt == msg_q.length) begin
						state     <= ST_CLOSE1;
						byte_data <= DELIM_CHAR;
					end else begin
						byte_data <= cur_char;
						byte_cnt  <= byte_cnt + 1'b1;
					end
				end
				ST_CLOSE1: if (byte_done) begin
					state     <= ST_CLOSE2;
					byte_data <= DELIM_CHAR;
					byte_req  <= 1'b1;
				end
				ST_CLOSE2: if (byte_done)
					state <= ST_FINISH;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// message held for the whole frame, length clipped to MAX_CHARS
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			msg_q.text   <= tx_msg.text;
			msg_q.length <= (tx_msg.length > LEN_W'(MAX_CHARS)) ?
				LEN_W'(MAX_CHARS) : tx_msg.length;
		end
	end

	a_done_single_cycle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done
	) else $error("str_framer: tx_done held for two cycles");

endmodule

//--- hw/uart_rx.sv
//==========================================================================
// uart byte receiver, 8N1
// synchronizes the line, centers on the start bit, samples each bit
// mid-period and checks the stop bit
//==========================================================================
module uart_rx (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic                               rx,
	output logic [uart_str_pkg::DATA_BITS-1:0] byte_data,
	output logic                               byte_vld,
	output logic                               stop_err
);
	import uart_str_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t            state;
	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [2:0]           bit_idx;
	logic                 half_end;
	logic                 bit_end;

	assign half_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1));
	assign bit_end  = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			byte_vld <= 1'b0;
			stop_err <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			stop_err <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: if (half_end) begin
					// line back high at mid-bit means a glitch
					clk_cnt <= '0;
					bit_idx <= '0;
					state   <= rx_sync ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (bit_end) begin
					clk_cnt <= '0;
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'(DATA_BITS - 1))
						state <= RX_STOP;
				end
				RX_STOP: if (bit_end) begin
					byte_vld <= rx_sync;
					stop_err <= !rx_sync;
					state    <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_end)
			byte_data <= {rx_sync, byte_data[DATA_BITS-1:1]};
	end

endmodule

//--- hw/uart_str_pkg.sv
//==========================================================================
// uart string link package
// character and frame widths, serial bit period, delimiter character
// and the string message carried between host, framer and deframer
//==========================================================================
package uart_str_pkg;

	// character width on the serial line
	localparam int DATA_BITS = 8;

	// longest content between the delimiters
	localparam int MAX_CHARS = 16;

	// packed string field, character 0 in the low byte
	localparam int STR_W = MAX_CHARS * DATA_BITS;

	// length field holds 0 to MAX_CHARS
	localparam int LEN_W = $clog2(MAX_CHARS + 1);

	// system clocks per serial bit
	localparam int CLKS_PER_BIT = 16;

	// counter width for one bit period
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

	// frame delimiter, sent twice at each end
	localparam logic [DATA_BITS-1:0] DELIM_CHAR = 8'h26;

	// one string with its length
	typedef struct packed {
		logic [STR_W-1:0] text;
		logic [LEN_W-1:0] length;
	} str_msg_t;

endpackage

//--- hw/uart_str_top.sv
//==========================================================================
// uart string link top level
// transmit path framer into byte transmitter, receive path byte
// receiver into deframer, both on the serial pins
//==========================================================================
module uart_str_top (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,

	// host transmit side
	input  uart_str_pkg::str_msg_t tx_msg,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,

	// host receive side
	output uart_str_pkg::str_msg_t rx_msg,
	output logic                   rx_busy,
	output logic                   rx_done,
	output logic                   rx_error,

	// serial pins, idle high
	input  logic                   uart_rx_port,
	output logic                   uart_tx_port
);
	import uart_str_pkg::*;

	logic [DATA_BITS-1:0] tx_byte_data;
	logic                 tx_byte_req;
	logic                 tx_byte_done;
	logic [DATA_BITS-1:0] rx_byte_data;
	logic                 rx_byte_vld;
	logic                 rx_stop_err;

	str_framer u_str_framer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_msg    (tx_msg),
		.tx_req    (tx_req),
		.byte_done (tx_byte_done),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req),
		.tx        (uart_tx_port),
		.byte_done (tx_byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.byte_data (rx_byte_data),
		.byte_vld  (rx_byte_vld),
		.stop_err  (rx_stop_err)
	);

	str_deframer u_str_deframer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (rx_byte_data),
		.byte_vld  (rx_byte_vld),
		.stop_err  (rx_stop_err),
		.rx_msg    (rx_msg),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

//--- hw/uart_tx.sv
//==========================================================================
// uart byte transmitter, 8N1
// serializes one byte per request, LSB first, at a fixed bit period
// and pulses byte_done once the stop bit has ended
//==========================================================================
module uart_tx (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic [uart_str_pkg::DATA_BITS-1:0] byte_data,
	input  logic                               byte_req,
	output logic                               tx,
	output logic                               byte_done
);
	import uart_str_pkg::*;

	logic                 busy;
	logic [BIT_CNT_W-1:0] clk_cnt;
	// 0 is the start bit, DATA_BITS+1 the stop bit
	logic [3:0]           bit_idx;
	// data bits followed by the stop bit
	logic [DATA_BITS:0]   shift;
	logic                 bit_end;

	assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy      <= 1'b0;
			clk_cnt   <= '0;
			bit_idx   <= '0;
			tx        <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (byte_req) begin
					// start bit goes out right away
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
					tx      <= 1'b0;
				end
			end else if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == 4'(DATA_BITS + 1)) begin
					busy      <= 1'b0;
					byte_done <= 1'b1;
					tx        <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					tx      <= shift[0];
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// shifts right at each bit boundary, ones fill in behind
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req)
			shift <= {1'b1, byte_data};
		else if (busy && bit_end)
			shift <= {1'b1, shift[DATA_BITS:1]};
	end

	// the framer must wait for byte_done before the next request
	a_no_req_while_busy: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !busy
	) else $error("uart_tx: byte_req while a byte is in progress");

endmodule

//--- verif/tb_uart_str.sv
//==========================================================================
// uart string link testbench
// table-driven loopback and direct serial frames against uart_str_top
//==========================================================================
module tb_uart_str;
	timeunit 1ns;
	timeprecision 1ps;
	import uart_str_pkg::*;

	localparam int M_LOOP = 0;
	localparam int M_BUSY = 1;
	localparam int M_LONG = 2;
	localparam int M_BAD  = 3;
	localparam int M_DRV  = 4;

	typedef struct {
		int       mode;
		str_msg_t msg;
		bit       exp_err;
	} row_t;

	logic     sys_clk;
	logic     sys_rst_n;
	str_msg_t tx_msg;
	logic     tx_req;
	logic     tx_busy;
	logic     tx_done;
	str_msg_t rx_msg;
	logic     rx_busy;
	logic     rx_done;
	logic     rx_error;
	logic     uart_rx_port;
	logic     uart_tx_port;
	logic     loop_sel;
	logic     line_drv;

	row_t        rows[$];
	logic [15:0] lfsr;
	str_msg_t    got;
	logic        busy_q;
	int          errors;
	int          cyc;
	int          limit;
	int          wd_cnt;
	int          txd_cnt;
	int          rxd_cnt;
	int          rxe_cnt;
	int          txd_cyc;
	int          rxd_cyc;

	uart_str_top u_uart_str_top (.*);

	// receive pin from the transmit pin or from the serial driver
	assign uart_rx_port = loop_sel ? uart_tx_port : line_drv;

	always #50 sys_clk = ~sys_clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic int rand_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	function automatic str_msg_t pack_str(input string s);
		str_msg_t m;
		int       i;
		m = '0;
		for (i = 0; i < s.len() && i < MAX_CHARS; i++)
			m.text[DATA_BITS*i +: DATA_BITS] = s[i];
		m.length = LEN_W'(s.len());
		return m;
	endfunction

	function automatic str_msg_t rand_msg();
		str_msg_t             m;
		int                   i;
		logic [DATA_BITS-1:0] c;
		m = '0;
		m.length = LEN_W'(rand_bits(5) % (MAX_CHARS + 1));
		for (i = 0; i < m.length; i++) begin
			c = DATA_BITS'(rand_bits(DATA_BITS));
			// no ampersand inside random content
			if (c == DELIM_CHAR)
				c = 8'h41;
			m.text[DATA_BITS*i +: DATA_BITS] = c;
		end
		return m;
	endfunction

	function automatic void add_row(input int mode, input str_msg_t msg, input bit exp_err);
		row_t r;
		r.mode    = mode;
		r.msg     = msg;
		r.exp_err = exp_err;
		rows.push_back(r);
	endfunction

	// single status bit, x counts as wrong
	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// one clock, sampled at the falling edge
	task automatic tick();
		@(negedge sys_clk);
		cyc++;
		if (tx_done) begin
			txd_cnt++;
			txd_cyc = cyc;
		end
		if (rx_done) begin
			rxd_cnt++;
			rxd_cyc = cyc;
			got = rx_msg;
		end
		if (rx_error)
			rxe_cnt++;
		// a frame must be open right before it ends
		if ((rx_done || rx_error) && busy_q !== 1'b1) begin
			errors++;
			$display("Fail rx_busy: expected %h, got %h", 1'b1, busy_q);
		end
		busy_q = rx_busy;
	endtask

	task automatic send_byte(input logic [DATA_BITS-1:0] b, input bit bad_stop);
		int i;
		line_drv = 1'b0;
		repeat (CLKS_PER_BIT) tick();
		for (i = 0; i < DATA_BITS; i++) begin
			line_drv = b[i];
			repeat (CLKS_PER_BIT) tick();
		end
		line_drv = !bad_stop;
		repeat (CLKS_PER_BIT) tick();
		// one idle bit between bytes
		line_drv = 1'b1;
		repeat (CLKS_PER_BIT) tick();
	endtask

	// bad frames end early, the last content byte of M_BAD has a low stop bit
	task automatic send_frame(input str_msg_t m, input int mode);
		int                   i;
		logic [DATA_BITS-1:0] c;
		send_byte(DELIM_CHAR, 1'b0);
		send_byte(DELIM_CHAR, 1'b0);
		for (i = 0; i < m.length; i++) begin
			c = (i < MAX_CHARS) ? m.text[DATA_BITS*i +: DATA_BITS] : 8'h71;
			send_byte(c, mode == M_BAD && i == m.length - 1);
		end
		if (mode == M_DRV) begin
			send_byte(DELIM_CHAR, 1'b0);
			send_byte(DELIM_CHAR, 1'b0);
		end
	endtask

	task automatic run_row(input row_t r);
		int start;
		txd_cnt  = 0;
		rxd_cnt  = 0;
		rxe_cnt  = 0;
		txd_cyc  = 0;
		rxd_cyc  = 0;
		got      = '0;
		loop_sel = (r.mode == M_LOOP || r.mode == M_BUSY);
		if (loop_sel) begin
			tx_msg = r.msg;
			tx_req = 1'b1;
			tick();
			tx_req = 1'b0;
			start  = cyc;
			while (txd_cnt == 0 || rxd_cnt + rxe_cnt == 0) begin
				tick();
				// second request in the middle of the frame
				tx_req = (r.mode == M_BUSY) && (cyc == start + 5 * CLKS_PER_BIT);
				if (tx_req) begin
					tx_msg = pack_str("zzzz");
					if (tx_busy !== 1'b1) begin
						errors++;
						$display("ERROR: tx_busy was low when the second request was raised");
					end
				end
			end
			tx_req = 1'b0;
		end else begin
			send_frame(r.msg, r.mode);
		end
		// quiet tail to catch stray pulses
		repeat (20 * CLKS_PER_BIT) tick();
		// no frame may go out on the transmit pin in driver rows
		if (txd_cnt != (loop_sel ? 1 : 0)) begin
			errors++;
			$display("Fail tx_done count: expected %0h, got %0h", loop_sel, txd_cnt);
		end
		if (rxd_cnt != (r.exp_err ? 0 : 1)) begin
			errors++;
			$display("Fail rx_done count: expected %0h, got %0h", !r.exp_err, rxd_cnt);
		end
		if (rxe_cnt != (r.exp_err ? 1 : 0)) begin
			errors++;
			$display("Fail rx_error count: expected %0h, got %0h", r.exp_err, rxe_cnt);
		end
		if (!r.exp_err && got.text != r.msg.text) begin
			errors++;
			$display("Fail rx_msg.text: expected %h, got %h", r.msg.text, got.text);
		end
		if (!r.exp_err && got.length != r.msg.length) begin
			errors++;
			$display("Fail rx_msg.length: expected %h, got %h", r.msg.length, got.length);
		end
		check_flag("rx_busy", 1'b0, rx_busy);
		// last byte lands mid stop bit, before the transmitter finishes
		if (loop_sel && rxd_cnt == 1 && rxd_cyc + CLKS_PER_BIT < txd_cyc) begin
			errors++;
			$display("ERROR: rx_done came more than a bit period before tx_done");
		end
	endtask

	initial begin
		wait (limit != 0);
		for (wd_cnt = 0; wd_cnt < limit; wd_cnt++)
			@(posedge sys_clk);
		$display("ERROR: timeout, the run did not finish within %0d cycles", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		tx_msg    = '0;
		tx_req    = 1'b0;
		loop_sel  = 1'b1;
		line_drv  = 1'b1;
		busy_q    = 1'b0;
		lfsr      = 16'd99;
		errors    = 0;
		cyc       = 0;
		limit     = 0;

		add_row(M_LOOP, pack_str("x"), 1'b0);
		add_row(M_LOOP, pack_str("hello"), 1'b0);
		add_row(M_LOOP, pack_str("0123456789abcdef"), 1'b0);
		add_row(M_LOOP, pack_str(""), 1'b0);
		add_row(M_LOOP, pack_str("a&b"), 1'b0);
		add_row(M_BUSY, pack_str("first"), 1'b0);
		add_row(M_LONG, pack_str("abcdefghijklmnopq"), 1'b1);
		add_row(M_BAD, pack_str("ab"), 1'b1);
		add_row(M_DRV, pack_str("ok!"), 1'b0);
		repeat (8) add_row(M_LOOP, rand_msg(), 1'b0);
		foreach (rows[i])
			limit += (int'(rows[i].msg.length) + 4) * 10 * CLKS_PER_BIT * 2;
		limit += 1000;

		repeat (2) tick();
		sys_rst_n = 1'b1;
		tick();
		check_flag("tx_busy", 1'b0, tx_busy);
		check_flag("tx_done", 1'b0, tx_done);
		check_flag("rx_busy", 1'b0, rx_busy);
		check_flag("rx_done", 1'b0, rx_done);
		check_flag("rx_error", 1'b0, rx_error);
		check_flag("uart_tx_port", 1'b1, uart_tx_port);
		if (rx_msg !== '0) begin
			errors++;
			$display("Fail rx_msg: expected %h, got %h", str_msg_t'(0), rx_msg);
		end

		foreach (rows[i])
			run_row(rows[i]);

		$display("summary: %0d rows run, %0d errors", rows.size(), errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
